// ==== mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

////////////////////
// Datapath sizing
////////////////////

// Word width for instructions, addresses and APB data
`define MIPS_XLEN 32

// Instruction memory depth in words
// Any power of two up to 256 fits the APB window below 0x400
`define IMEM_DEPTH 256

// Word index width, log2 of the depth
// Keep in step with IMEM_DEPTH by hand
`define IMEM_AW 8

// Bytes per instruction word
`define MIPS_WORD_BYTES 4

`endif

// ==== mips_isa_pkg.sv ====
`default_nettype none

`include "mips_config.svh"

package mips_isa_pkg;

	////////////////////
	// Datapath types
	////////////////////

	// One instruction or data word
	typedef logic [`MIPS_XLEN-1:0] word_t;

	// Byte address, used for the program counter and jump targets
	typedef logic [`MIPS_XLEN-1:0] addr_t;

	// Word index into the instruction memory
	typedef logic [`IMEM_AW-1:0] imem_idx_t;

	////////////////////
	// Derived sizes
	////////////////////

	// Step of the counter on a plain fetch
	localparam int unsigned INSTR_BYTES = `MIPS_WORD_BYTES;

	// Byte span of the whole instruction memory
	localparam int unsigned IMEM_BYTES = `MIPS_WORD_BYTES * `IMEM_DEPTH;

endpackage

`default_nettype wire

// ==== apb_pkg.sv ====
`default_nettype none

`include "mips_config.svh"

package apb_pkg;

	////////////////////
	// Bus types
	////////////////////

	// 12 bit address space covers the memory window and the registers
	typedef logic [11:0] apb_addr_t;

	// Data bus matches the datapath word
	typedef logic [`MIPS_XLEN-1:0] apb_data_t;

	////////////////////
	// Register map
	////////////////////

	// Instruction memory window, 4 bytes per word
	localparam apb_addr_t IMEM_BASE = 12'h000;
	// Control register, bit 0 is run
	localparam apb_addr_t CTRL_OFF  = 12'h400;
	localparam int unsigned CTRL_RUN_BIT = 0;
	// Program counter readback, read only
	localparam apb_addr_t PC_OFF    = 12'h404;

endpackage

`default_nettype wire

// ==== fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module fetch_ctrl
	import mips_isa_pkg::*;
	import apb_pkg::*;
(
	input  wire logic      clock,
	input  wire logic      rst_n,
	// APB slave side
	input  wire logic      psel,
	input  wire logic      penable,
	input  wire logic      pwrite,
	input  wire apb_addr_t paddr,
	input  wire apb_data_t pwdata,
	output apb_data_t      prdata,
	output logic           pready,
	output logic           pslverr,
	// Counter readback and run control
	input  wire addr_t     pc,
	output logic           run,
	// Host port of the instruction memory
	output logic           mem_we,
	output imem_idx_t      mem_idx,
	output word_t          mem_wdata,
	input  wire word_t     mem_rdata
);

	// End of the memory window, exclusive
	localparam apb_addr_t IMEM_SPAN = apb_addr_t'(IMEM_BYTES);

	logic      access;
	logic      is_write;
	logic      is_read;
	apb_addr_t imem_off;
	logic      hit_imem;
	logic      hit_ctrl;
	logic      hit_pc;
	logic      unmapped;
	logic      bad_access;
	logic      ctrl_wr;

	////////////////////
	// Address decode
	////////////////////

	// Access phase of a transfer, no wait states
	assign access   = psel && penable;
	assign is_write = access && pwrite;
	assign is_read  = access && !pwrite;

	// Offset into the memory window, wraps below the base so it misses
	assign imem_off = paddr - IMEM_BASE;
	assign hit_imem = imem_off < IMEM_SPAN;
	assign hit_ctrl = paddr == CTRL_OFF;
	assign hit_pc   = paddr == PC_OFF;
	assign unmapped = !(hit_imem || hit_ctrl || hit_pc);

	// Error cases
	// Counter is read only, and the program must not change under a running fetch
	assign bad_access = unmapped
		|| (pwrite && hit_pc)
		|| (pwrite && hit_imem && run);

	assign pready  = 1'b1;
	assign pslverr = access && bad_access;

	////////////////////
	// Memory host port
	////////////////////

	// Low two address bits select a byte and are ignored
	assign mem_idx   = imem_off[`IMEM_AW+1:2];
	assign mem_wdata = pwdata;
	// Write only when the access is accepted
	assign mem_we    = is_write && hit_imem && !bad_access;

	////////////////////
	// Run bit
	////////////////////

	assign ctrl_wr = is_write && hit_ctrl;

	// Takes effect at the edge closing the access phase
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run <= 1'b0;
		end else if (ctrl_wr) begin
			run <= pwdata[CTRL_RUN_BIT];
		end
	end

	////////////////////
	// Read data mux
	////////////////////

	always_comb begin
		prdata = '0;
		if (is_read) begin
			if (hit_imem) begin
				prdata = mem_rdata;
			end else if (hit_ctrl) begin
				prdata[CTRL_RUN_BIT] = run;
			end else if (hit_pc) begin
				// Counter of the current cycle
				prdata = apb_data_t'(pc);
			end
		end
	end

	// Enable only inside a transfer already selected in the previous cycle
	a_penable_in_transfer: assert property (
		@(posedge clock) disable iff (!rst_n)
		penable |-> psel && $past(psel)
	);

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_unit
	import mips_isa_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  rst_n,
	input  wire logic  run,
	// Branch controls from outside the stage
	input  wire logic  control_is_jump,
	input  wire logic  control_branch_eq,
	input  wire logic  control_branch_inc,
	input  wire logic  control_is_zero,
	input  wire addr_t data_jump_address,
	output addr_t      pc
);

	// Keeps the counter word aligned and inside the memory
	localparam addr_t WRAP_MASK = addr_t'(IMEM_BYTES - 1) & ~addr_t'(INSTR_BYTES - 1);

	logic  take_eq;
	logic  take_ne;
	logic  uncond;
	logic  redirect;
	addr_t seq_pc;
	addr_t next_pc;

	////////////////////
	// Redirect rule
	////////////////////

	// beq taken on zero and bne taken on non zero
	assign take_eq = control_branch_eq && control_is_zero;
	assign take_ne = control_branch_inc && !control_is_zero;
	// No branch flag means a plain jump
	assign uncond  = !control_branch_eq && !control_branch_inc;

	// Jump request gates every case
	assign redirect = control_is_jump && (take_eq || take_ne || uncond);

	////////////////////
	// Next counter
	////////////////////

	assign seq_pc = pc + addr_t'(INSTR_BYTES);

	// Target low bits and out of range bits dropped by the mask
	assign next_pc = (redirect ? data_jump_address : seq_pc) & WRAP_MASK;

	// Holds while the host keeps run low
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (run) begin
			pc <= next_pc;
		end
	end

	// Word aligned and inside the memory at every edge
	a_pc_in_range: assert property (
		@(posedge clock) disable iff (!rst_n)
		pc[1:0] == 2'b00 && pc < addr_t'(IMEM_BYTES)
	);

endmodule

`default_nettype wire

// ==== instr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module instr_mem
	import mips_isa_pkg::*;
(
	input  wire logic      clock,
	// Fetch port
	input  wire addr_t     pc,
	output word_t          instruction,
	// Host port from the APB decoder
	input  wire logic      mem_we,
	input  wire imem_idx_t mem_idx,
	input  wire word_t     mem_wdata,
	output word_t          mem_rdata
);

	// Program storage, contents survive reset
	word_t     mem [`IMEM_DEPTH];

	imem_idx_t fetch_idx;

	////////////////////
	// Fetch read
	////////////////////

	// Byte address to word index
	assign fetch_idx   = pc[`IMEM_AW+1:2];

	// Word at the new pc in the same cycle pc changes
	assign instruction = mem[fetch_idx];

	////////////////////
	// Host port
	////////////////////

	// Readback is combinational, valid in the APB access phase
	assign mem_rdata = mem[mem_idx];

	always_ff @(posedge clock) begin
		if (mem_we) begin
			mem[mem_idx] <= mem_wdata;
		end
	end

	// A host write to the word being fetched happens only while pc is stopped
	a_no_write_under_fetch: assert property (
		@(posedge clock)
		mem_we && (mem_idx == fetch_idx) |=> $stable(pc)
	);

endmodule

`default_nettype wire

// ==== stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_if
	import mips_isa_pkg::*;
	import apb_pkg::*;
(
	input  wire logic      clock,
	input  wire logic      rst_n,
	// APB host port
	input  wire logic      psel,
	input  wire logic      penable,
	input  wire logic      pwrite,
	input  wire apb_addr_t paddr,
	input  wire apb_data_t pwdata,
	output apb_data_t      prdata,
	output logic           pready,
	output logic           pslverr,
	// Branch controls
	input  wire logic      control_is_jump,
	input  wire logic      control_branch_eq,
	input  wire logic      control_branch_inc,
	input  wire logic      control_is_zero,
	input  wire addr_t     data_jump_address,
	// Fetched word and its address
	output word_t          instruction,
	output addr_t          pc
);

	logic      run;
	logic      mem_we;
	imem_idx_t mem_idx;
	word_t     mem_wdata;
	word_t     mem_rdata;

	////////////////////
	// Register decoder
	////////////////////

	fetch_ctrl u_ctrl (
		.clock(clock), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.pc(pc), .run(run),
		.mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	// Counter, steps once per running cycle
	pc_unit u_pc (
		.clock(clock), .rst_n(rst_n), .run(run),
		.control_is_jump(control_is_jump), .control_branch_eq(control_branch_eq),
		.control_branch_inc(control_branch_inc), .control_is_zero(control_is_zero),
		.data_jump_address(data_jump_address), .pc(pc)
	);

	// Program store, returns the fetched word
	instr_mem u_mem (
		.clock(clock), .pc(pc), .instruction(instruction),
		.mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free running testbench clock, low at time zero
module clock_gen #(
	parameter int PERIOD = 10
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
	end

	// Half period per toggle
	always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire

// ==== tb_stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module tb_stage_if
	import mips_isa_pkg::*;
	import apb_pkg::*;
();

	localparam int CLK_PERIOD  = 10;
	localparam int DEPTH       = `IMEM_DEPTH;
	localparam int IMEM_WINDOW = 4 * DEPTH;
	localparam int RAND_WRITES = 32;
	localparam int RAND_CYCLES = 300;
	// Cycle budget of all phases with three cycles per APB transfer
	localparam int PLANNED_CYCLES = 60 + 3 * (2 * DEPTH + RAND_WRITES)
		+ DEPTH + RAND_CYCLES + 120;

	logic      clock;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      control_is_jump;
	logic      control_branch_eq;
	logic      control_branch_inc;
	logic      control_is_zero;
	addr_t     data_jump_address;
	word_t     instruction;
	addr_t     pc;

	// Reference state of the stage
	addr_t     model_pc;
	logic      model_run;
	word_t     model_mem [DEPTH];

	int        check_count = 0;
	int        mismatch_count = 0;
	int        other_count = 0;
	int        wrap_count = 0;
	addr_t     prev_pc;

	clock_gen #(.PERIOD(CLK_PERIOD)) clk_gen (.clock(clock));

	stage_if uut (
		.clock(clock), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.control_is_jump(control_is_jump), .control_branch_eq(control_branch_eq),
		.control_branch_inc(control_branch_inc), .control_is_zero(control_is_zero),
		.data_jump_address(data_jump_address),
		.instruction(instruction), .pc(pc)
	);

	////////////////////
	// Reference model
	////////////////////

	// Next counter from the redirect rule and the wrap to the memory size
	function automatic addr_t next_pc_model(input addr_t cur, input logic jump,
			input logic beq, input logic bne, input logic zero, input addr_t target);
		logic  taken;
		addr_t nxt;
		taken = jump && ((beq && zero) || (bne && !zero) || (!beq && !bne));
		if (taken) begin
			nxt = {target[`MIPS_XLEN-1:2], 2'b00};
		end else begin
			nxt = cur + 32'd4;
		end
		return nxt % addr_t'(IMEM_WINDOW);
	endfunction

	// Expected slave error for an access under the run bit of that cycle
	function automatic logic bus_error(input apb_addr_t addr, input logic write,
			input logic running);
		logic in_mem;
		logic mapped;
		in_mem = int'(addr) < IMEM_WINDOW;
		mapped = in_mem || addr == CTRL_OFF || addr == PC_OFF;
		if (!mapped) begin
			return 1'b1;
		end
		if (write && addr == PC_OFF) begin
			return 1'b1;
		end
		return write && in_mem && running;
	endfunction

	// Follows the bus and the controls at every rising edge
	always @(posedge clock) begin
		logic accept;
		if (!rst_n) begin
			model_pc  = '0;
			model_run = 1'b0;
		end else begin
			// Acceptance uses the run bit before this edge
			accept = psel && penable && pwrite && !bus_error(paddr, 1'b1, model_run);
			if (model_run) begin
				model_pc = next_pc_model(model_pc, control_is_jump, control_branch_eq,
					control_branch_inc, control_is_zero, data_jump_address);
			end
			if (accept && paddr == CTRL_OFF) begin
				model_run = pwdata[0];
			end else if (accept) begin
				model_mem[paddr[`IMEM_AW+1:2]] = pwdata;
			end
		end
	end

	////////////////////
	// Checker
	////////////////////

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s dut=%h expected=%h", $time, name, got, exp);
		end
	endtask

	// Compare well after the edge once pc and the fetch read have settled
	always @(posedge clock) begin
		#2;
		if (rst_n) begin
			check_word("pc", pc, model_pc);
			check_word("instruction", instruction, model_mem[model_pc[`IMEM_AW+1:2]]);
			if (prev_pc == addr_t'(IMEM_WINDOW - 4) && pc == '0) begin
				wrap_count++;
			end
			prev_pc = pc;
		end
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	// Setup, access and one idle cycle driven on falling edges
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		logic exp_err;
		@(negedge clock);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clock);
		penable = 1'b1;
		exp_err = bus_error(addr, 1'b1, model_run);
		#1;
		check_word("pready", {31'b0, pready}, 32'h1);
		check_word("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Read data and the model counter both taken mid access phase
	task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
			output addr_t pc_then);
		logic exp_err;
		@(negedge clock);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clock);
		penable = 1'b1;
		exp_err = bus_error(addr, 1'b0, model_run);
		#1;
		data    = prdata;
		pc_then = model_pc;
		check_word("pready", {31'b0, pready}, 32'h1);
		check_word("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// One cycle of branch controls
	task automatic drive_controls(input logic jump, input logic beq, input logic bne,
			input logic zero, input addr_t target);
		@(negedge clock);
		control_is_jump    = jump;
		control_branch_eq  = beq;
		control_branch_inc = bne;
		control_is_zero    = zero;
		data_jump_address  = target;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		apb_data_t rd;
		addr_t     pc_then;
		word_t     rnd;
		int        idx;
		void'($urandom(87508));
		rst_n              = 1'b0;
		psel               = 1'b0;
		penable            = 1'b0;
		pwrite             = 1'b0;
		paddr              = '0;
		pwdata             = '0;
		control_is_jump    = 1'b0;
		control_branch_eq  = 1'b0;
		control_branch_inc = 1'b0;
		control_is_zero    = 1'b0;
		data_jump_address  = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// Reset state and then a stopped counter that ignores a jump request
		check_word("pslverr", {31'b0, pslverr}, 32'h0);
		apb_read(PC_OFF, rd, pc_then);
		check_word("prdata", rd, 32'h0);
		drive_controls(1'b1, 1'b0, 1'b0, 1'b0, 32'h80);
		repeat (20) @(negedge clock);
		check_word("pc", pc, 32'h0);
		drive_controls(1'b0, 1'b0, 1'b0, 1'b0, '0);

		// Program load with the index pattern and then random words
		for (int i = 0; i < DEPTH; i++) begin
			apb_write(IMEM_BASE + apb_addr_t'(i * 4), word_t'(i * 4));
		end
		repeat (RAND_WRITES) begin
			idx = $urandom % DEPTH;
			apb_write(IMEM_BASE + apb_addr_t'(idx * 4), $urandom);
		end
		for (int i = 0; i < DEPTH; i++) begin
			apb_read(IMEM_BASE + apb_addr_t'(i * 4), rd, pc_then);
			check_word("prdata", rd, model_mem[imem_idx_t'(i)]);
		end

		// Sequential fetch through the whole memory and past the wrap
		apb_write(CTRL_OFF, 32'h1);
		repeat (DEPTH + 16) @(negedge clock);
		assert (wrap_count > 0) else begin
			other_count++;
			$display("pc never wrapped from the last word back to 0");
		end

		// Directed jump, beq and bne cases
		drive_controls(1'b1, 1'b0, 1'b0, 1'b0, 32'h100);
		drive_controls(1'b1, 1'b1, 1'b0, 1'b1, 32'h200);
		drive_controls(1'b1, 1'b1, 1'b0, 1'b0, 32'h300);
		drive_controls(1'b1, 1'b0, 1'b1, 1'b0, 32'h040);
		drive_controls(1'b1, 1'b0, 1'b1, 1'b1, 32'h080);
		drive_controls(1'b0, 1'b1, 1'b0, 1'b1, 32'h3F0);
		drive_controls(1'b1, 1'b1, 1'b1, 1'b1, 32'h123);
		drive_controls(1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_3FFE);
		// Jump to the last word and a plain step that wraps to 0
		drive_controls(1'b1, 1'b0, 1'b0, 1'b0, 32'h3FC);
		drive_controls(1'b0, 1'b0, 1'b0, 1'b0, '0);

		// Random control mixes and targets
		repeat (RAND_CYCLES) begin
			rnd = $urandom;
			drive_controls(rnd[0], rnd[1], rnd[2], rnd[3], $urandom);
		end
		drive_controls(1'b0, 1'b0, 1'b0, 1'b0, '0);

		// Rejected accesses while running
		apb_write(PC_OFF, 32'h100);
		apb_read(12'h408, rd, pc_then);
		apb_write(12'h800, 32'h5A5A_5A5A);
		apb_read(12'hFFC, rd, pc_then);
		apb_write(IMEM_BASE + 12'h010, 32'hDEAD_BEEF);
		apb_read(PC_OFF, rd, pc_then);
		check_word("prdata", rd, pc_then);
		apb_read(CTRL_OFF, rd, pc_then);
		check_word("prdata", rd, 32'h1);

		// Stopped fetch where the rejected words still hold their old values
		apb_write(CTRL_OFF, 32'h0);
		apb_read(IMEM_BASE + 12'h010, rd, pc_then);
		check_word("prdata", rd, model_mem[4]);
		// Word 0 is where a wrongly decoded 0x800 write would land
		apb_read(IMEM_BASE, rd, pc_then);
		check_word("prdata", rd, model_mem[0]);
		apb_write(IMEM_BASE + 12'h010, 32'hCAFE_0010);
		apb_read(IMEM_BASE + 12'h010, rd, pc_then);
		check_word("prdata", rd, model_mem[4]);
		apb_read(PC_OFF, rd, pc_then);
		check_word("prdata", rd, pc_then);

		repeat (4) @(negedge clock);
		$display("Checks %0d, mismatches %0d, other failures %0d",
			check_count, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((PLANNED_CYCLES + 200) * CLK_PERIOD);
		other_count++;
		$display("Timeout after %0d cycles, the test sequence did not finish",
			PLANNED_CYCLES + 200);
		$display("Checks %0d, mismatches %0d, other failures %0d",
			check_count, mismatch_count, other_count);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
mips_isa_pkg.sv
apb_pkg.sv
fetch_ctrl.sv
pc_unit.sv
instr_mem.sv
stage_if.sv
clock_gen.sv
tb_stage_if.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

TOP := tb_stage_if
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q -x '\*\* PASS \*\*' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
